// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Address split: tag | index | byte offset.
    localparam int offset_bits = 5;
    localparam int index_bits  = 4;
    localparam int tag_bits    = 23;

    localparam int num_ways  = 4;
    localparam int num_sets  = 16;
    localparam int line_bits = 256;
    localparam int mask_bits = 32;
    localparam int byte_bits = line_bits / mask_bits;

    typedef logic [tag_bits+index_bits+offset_bits-1:0] addr_t;
    typedef logic [line_bits-1:0]                       line_t;
    typedef logic [mask_bits-1:0]                       mask_t;
    typedef logic [tag_bits-1:0]                        tag_t;
    typedef logic [index_bits-1:0]                      index_t;
    typedef logic [1:0]                                 way_t;

    // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3.
    typedef logic [2:0] plru_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill,
        st_refetch
    } cache_state_t;

endpackage : cache_pkg

`default_nettype wire

// ==== source/cache_data_array.sv ====
`default_nettype none

module cache_data_array
    import cache_pkg::*;
#(
    parameter int num_lines = num_sets
) (
    input  wire    clk,
    input  wire    we,
    input  wire mask_t  wmask,
    input  wire index_t index,
    input  wire line_t  wdata,
    output line_t  rdata
);

    line_t mem [num_lines];

    // Byte-masked write; read is registered, so a write shows up one cycle later.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < mask_bits; b++) begin
                if (wmask[b]) begin
                    mem[index][byte_bits*b +: byte_bits] <= wdata[byte_bits*b +: byte_bits];
                end
            end
        end
        rdata <= mem[index];
    end

endmodule : cache_data_array

`default_nettype wire

// ==== source/cache_tag_array.sv ====
`default_nettype none

module cache_tag_array
    import cache_pkg::*;
#(
    parameter int num_lines = num_sets
) (
    input  wire         clk,
    input  wire         we,
    input  wire index_t index,
    input  wire tag_t   wtag,
    output tag_t        rtag
);

    tag_t mem [num_lines];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wtag;
        end
        rtag <= mem[index];
    end

endmodule : cache_tag_array

`default_nettype wire

// ==== source/cache_status_array.sv ====
`default_nettype none

module cache_status_array
    import cache_pkg::*;
#(
    parameter int num_lines = num_sets
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         we,
    input  wire index_t index,
    input  wire         wbit,
    output logic        rbit
);

    logic [num_lines-1:0] bits;

    // Status bits live in flops so that reset can clear every line.
    always_ff @(posedge clk) begin
        if (rst) begin
            bits <= '0;
            rbit <= 1'b0;
        end else begin
            if (we) begin
                bits[index] <= wbit;
            end
            rbit <= bits[index];
        end
    end

endmodule : cache_status_array

`default_nettype wire

// ==== source/cache_datapath.sv ====
`default_nettype none

module cache_datapath
    import cache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire addr_t  mem_address,
    input  wire mask_t  mem_byte_enable,
    input  wire line_t  mem_wdata,
    output line_t       mem_rdata,

    output addr_t       pmem_address,
    output line_t       pmem_wdata,
    input  wire line_t  pmem_rdata,

    input  wire         ld_data,
    input  wire         data_from_mem,
    input  wire         ld_tag,
    input  wire         ld_valid,
    input  wire         ld_dirty,
    input  wire         dirty_val,
    input  wire         dirty_on_victim,
    input  wire         ld_plru,
    input  wire         rdata_from_mem,
    input  wire         addr_from_victim,

    output logic        hit,
    output logic        victim_dirty
);

    tag_t   addr_tag;
    index_t addr_index;

    line_t  data_q  [num_ways];
    tag_t   tag_q   [num_ways];
    logic   valid_q [num_ways];
    logic   dirty_q [num_ways];

    logic [num_ways-1:0] way_match;
    logic [num_ways-1:0] victim_mask;
    way_t   hit_way;
    way_t   victim;

    plru_t  plru [num_sets];
    plru_t  plru_cur;
    plru_t  plru_next;

    mask_t  array_wmask;
    line_t  array_wdata;

    assign addr_tag   = mem_address[offset_bits+index_bits +: tag_bits];
    assign addr_index = mem_address[offset_bits +: index_bits];

    // A way hits only when it is valid and its tag matches.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            way_match[w] = valid_q[w] && (tag_q[w] == addr_tag);
            if (way_match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |way_match;

    assign plru_cur = plru[addr_index];

    always_comb begin
        if (plru_cur[0]) begin
            victim = plru_cur[1] ? way_t'(0) : way_t'(1);
        end else begin
            victim = plru_cur[2] ? way_t'(2) : way_t'(3);
        end
    end

    assign victim_mask  = num_ways'(1) << victim;
    assign victim_dirty = valid_q[victim] && dirty_q[victim];

    // Point the tree away from the way just used.
    always_comb begin
        plru_next = plru_cur;
        case (hit_way)
            2'd0: {plru_next[1], plru_next[0]} = 2'b00;
            2'd1: {plru_next[1], plru_next[0]} = 2'b10;
            2'd2: {plru_next[2], plru_next[0]} = 2'b01;
            default: {plru_next[2], plru_next[0]} = 2'b11;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                plru[s] <= '0;
            end
        end else if (ld_plru) begin
            plru[addr_index] <= plru_next;
        end
    end

    // Fills write a whole line, processor writes only the enabled bytes.
    assign array_wmask = data_from_mem ? '1 : mem_byte_enable;
    assign array_wdata = data_from_mem ? pmem_rdata : mem_wdata;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_data_array #(.num_lines(num_sets)) u_data (
            .clk   (clk),
            .we    (ld_data && (data_from_mem ? victim_mask[w] : way_match[w])),
            .wmask (array_wmask),
            .index (addr_index),
            .wdata (array_wdata),
            .rdata (data_q[w])
        );

        cache_tag_array #(.num_lines(num_sets)) u_tag (
            .clk   (clk),
            .we    (ld_tag && victim_mask[w]),
            .index (addr_index),
            .wtag  (addr_tag),
            .rtag  (tag_q[w])
        );

        cache_status_array #(.num_lines(num_sets)) u_valid (
            .clk   (clk),
            .rst   (rst),
            .we    (ld_valid && victim_mask[w]),
            .index (addr_index),
            .wbit  (1'b1),
            .rbit  (valid_q[w])
        );

        cache_status_array #(.num_lines(num_sets)) u_dirty (
            .clk   (clk),
            .rst   (rst),
            .we    (ld_dirty && (dirty_on_victim ? victim_mask[w] : way_match[w])),
            .index (addr_index),
            .wbit  (dirty_val),
            .rbit  (dirty_q[w])
        );
    end

    // Write-back goes to the victim's own line address.
    assign pmem_address = addr_from_victim ?
                          {tag_q[victim], addr_index, offset_bits'(0)} : mem_address;
    assign pmem_wdata   = data_q[victim];
    assign mem_rdata    = rdata_from_mem ? pmem_rdata : data_q[hit_way];

    // Fills always replace the victim, so no tag can land in two ways of a set.
    a_single_match : assert property (@(posedge clk) disable iff (rst)
        $onehot0(way_match));

    a_data_write_known : assert property (@(posedge clk) disable iff (rst)
        ld_data |-> !$isunknown(hit));

endmodule : cache_datapath

`default_nettype wire

// ==== source/cache_control.sv ====
`default_nettype none

module cache_control
    import cache_pkg::*;
(
    input  wire  clk,
    input  wire  rst,

    input  wire  mem_read,
    input  wire  mem_write,
    output logic mem_resp,

    output logic pmem_read,
    output logic pmem_write,
    input  wire  pmem_resp,

    input  wire  hit,
    input  wire  victim_dirty,

    output logic ld_data,
    output logic data_from_mem,
    output logic ld_tag,
    output logic ld_valid,
    output logic ld_dirty,
    output logic dirty_val,
    output logic dirty_on_victim,
    output logic ld_plru,
    output logic rdata_from_mem,
    output logic addr_from_victim
);

    cache_state_t state;
    cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state       = state;
        mem_resp         = 1'b0;
        pmem_read        = 1'b0;
        pmem_write       = 1'b0;
        ld_data          = 1'b0;
        data_from_mem    = 1'b0;
        ld_tag           = 1'b0;
        ld_valid         = 1'b0;
        ld_dirty         = 1'b0;
        dirty_val        = 1'b0;
        dirty_on_victim  = 1'b0;
        ld_plru          = 1'b0;
        rdata_from_mem   = 1'b0;
        addr_from_victim = 1'b0;

        case (state)
            st_idle: begin
                // Arrays are read at this edge and their outputs are valid in compare.
                if (mem_read || mem_write) begin
                    next_state = st_compare;
                end
            end

            st_compare: begin
                if (hit) begin
                    mem_resp   = 1'b1;
                    ld_plru    = 1'b1;
                    next_state = st_idle;
                    if (mem_write) begin
                        ld_data   = 1'b1;
                        ld_dirty  = 1'b1;
                        dirty_val = 1'b1;
                    end
                end else if (victim_dirty) begin
                    next_state = st_writeback;
                end else begin
                    next_state = st_fill;
                end
            end

            st_writeback: begin
                pmem_write       = 1'b1;
                addr_from_victim = 1'b1;
                if (pmem_resp) begin
                    next_state = st_fill;
                end
            end

            st_fill: begin
                pmem_read      = 1'b1;
                rdata_from_mem = 1'b1;
                if (pmem_resp) begin
                    // The whole line goes into the victim, which becomes valid and clean.
                    ld_data         = 1'b1;
                    data_from_mem   = 1'b1;
                    ld_tag          = 1'b1;
                    ld_valid        = 1'b1;
                    ld_dirty        = 1'b1;
                    dirty_on_victim = 1'b1;
                    next_state      = st_refetch;
                end
            end

            st_refetch: begin
                next_state = st_compare;
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

    a_one_request : assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write));

    // A memory response answers exactly one open memory operation.
    a_one_pmem_op : assert property (@(posedge clk) disable iff (rst)
        pmem_resp |-> (pmem_read ^ pmem_write));

endmodule : cache_control

`default_nettype wire

// ==== source/cache.sv ====
`default_nettype none

module cache
    import cache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire         mem_read,
    input  wire         mem_write,
    input  wire addr_t  mem_address,
    input  wire mask_t  mem_byte_enable,
    input  wire line_t  mem_wdata,
    output line_t       mem_rdata,
    output logic        mem_resp,

    output logic        pmem_read,
    output logic        pmem_write,
    output addr_t       pmem_address,
    output line_t       pmem_wdata,
    input  wire line_t  pmem_rdata,
    input  wire         pmem_resp
);

    logic hit;
    logic victim_dirty;
    logic ld_data;
    logic data_from_mem;
    logic ld_tag;
    logic ld_valid;
    logic ld_dirty;
    logic dirty_val;
    logic dirty_on_victim;
    logic ld_plru;
    logic rdata_from_mem;
    logic addr_from_victim;

    cache_control u_control (
        .clk              (clk),
        .rst              (rst),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_resp         (mem_resp),
        .pmem_read        (pmem_read),
        .pmem_write       (pmem_write),
        .pmem_resp        (pmem_resp),
        .hit              (hit),
        .victim_dirty     (victim_dirty),
        .ld_data          (ld_data),
        .data_from_mem    (data_from_mem),
        .ld_tag           (ld_tag),
        .ld_valid         (ld_valid),
        .ld_dirty         (ld_dirty),
        .dirty_val        (dirty_val),
        .dirty_on_victim  (dirty_on_victim),
        .ld_plru          (ld_plru),
        .rdata_from_mem   (rdata_from_mem),
        .addr_from_victim (addr_from_victim)
    );

    cache_datapath u_datapath (
        .clk              (clk),
        .rst              (rst),
        .mem_address      (mem_address),
        .mem_byte_enable  (mem_byte_enable),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .pmem_address     (pmem_address),
        .pmem_wdata       (pmem_wdata),
        .pmem_rdata       (pmem_rdata),
        .ld_data          (ld_data),
        .data_from_mem    (data_from_mem),
        .ld_tag           (ld_tag),
        .ld_valid         (ld_valid),
        .ld_dirty         (ld_dirty),
        .dirty_val        (dirty_val),
        .dirty_on_victim  (dirty_on_victim),
        .ld_plru          (ld_plru),
        .rdata_from_mem   (rdata_from_mem),
        .addr_from_victim (addr_from_victim),
        .hit              (hit),
        .victim_dirty     (victim_dirty)
    );

endmodule : cache

`default_nettype wire

// ==== verification/pmem_model.sv ====
`default_nettype none

module pmem_model
    import cache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         pmem_read,
    input  wire         pmem_write,
    input  wire addr_t  pmem_address,
    input  wire line_t  pmem_wdata,
    output line_t       pmem_rdata,
    output logic        pmem_resp,
    output int          wb_count
);

    localparam int latency = 3;

    line_t mem [addr_t];
    addr_t line_addr;
    int    wait_cycles;

    assign line_addr = {pmem_address[31:offset_bits], offset_bits'(0)};

    // Untouched lines hold a pattern built from their own address.
    function automatic line_t initial_line(addr_t a);
        line_t l;
        for (int k = 0; k < line_bits / 32; k++) begin
            l[32*k +: 32] = {a[31:offset_bits], offset_bits'(k)} ^ 32'h6c8e_9cf5;
        end
        return l;
    endfunction

    // The response skips the cycle after a pulse, so back-to-back requests count afresh.
    always @(posedge clk) begin
        pmem_resp <= 1'b0;
        if (rst) begin
            wait_cycles <= 0;
            wb_count    <= 0;
            pmem_rdata  <= '0;
        end else if ((pmem_read || pmem_write) && !pmem_resp) begin
            if (wait_cycles == latency - 1) begin
                wait_cycles <= 0;
                pmem_resp   <= 1'b1;
                if (pmem_write) begin
                    mem[line_addr] = pmem_wdata;
                    wb_count <= wb_count + 1;
                end else if (mem.exists(line_addr)) begin
                    pmem_rdata <= mem[line_addr];
                end else begin
                    pmem_rdata <= initial_line(line_addr);
                end
            end else begin
                wait_cycles <= wait_cycles + 1;
            end
        end
    end

endmodule : pmem_model

`default_nettype wire

// ==== verification/cache_tb.sv ====
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    typedef struct packed {
        logic        is_write;
        addr_t       addr;
        mask_t       mask;
        logic [31:0] seed;
        logic        exp_hit;
    } row_t;

    localparam int num_rows    = 15;
    localparam int cycle_limit = num_rows * 40;

    // Set 5 takes the hit and masked write traffic. Set 3 sees five tags.
    // A write with a zero mask draws a random mask.
    localparam row_t rows [num_rows] = '{
        '{1'b0, 32'h0000_02a0, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_02a0, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0000_02a0, 32'h0000_f00f, 32'h1111_0001, 1'b1},
        '{1'b0, 32'h0000_02a0, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0000_02a0, 32'h0000_0000, 32'h2222_0002, 1'b1},
        '{1'b0, 32'h0000_0260, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b1, 32'h0000_0460, 32'hff00_00ff, 32'h3333_0003, 1'b0},
        '{1'b0, 32'h0000_0660, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_0860, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_0a60, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_0260, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_0460, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_0860, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0000_02a0, 32'h0000_0000, 32'h4444_0004, 1'b1},
        '{1'b0, 32'h0000_0260, 32'h0000_0000, 32'h0000_0000, 1'b1}
    };

    logic  clk;
    logic  rst;
    logic  mem_read;
    logic  mem_write;
    addr_t mem_address;
    mask_t mem_byte_enable;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_resp;
    logic  pmem_read;
    logic  pmem_write;
    addr_t pmem_address;
    line_t pmem_wdata;
    line_t pmem_rdata;
    logic  pmem_resp;
    int    wb_count;

    int          errors      = 0;
    int          cycle_count = 0;
    int          wb_total    = 0;
    logic [15:0] lfsr;

    // Reference copy of the cache state and of the memory contents.
    tag_t  ref_tag   [num_sets][num_ways];
    logic  ref_valid [num_sets][num_ways];
    logic  ref_dirty [num_sets][num_ways];
    plru_t ref_plru  [num_sets];
    line_t shadow    [addr_t];

    cache u_dut (.*);

    pmem_model u_pmem (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles, errors %0d",
                     cycle_limit, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic line_t memory_line(addr_t a);
        line_t l;
        for (int k = 0; k < line_bits / 32; k++) begin
            l[32*k +: 32] = {a[31:offset_bits], offset_bits'(k)} ^ 32'h6c8e_9cf5;
        end
        return l;
    endfunction

    function automatic line_t shadow_line(addr_t a);
        return shadow.exists(a) ? shadow[a] : memory_line(a);
    endfunction

    function automatic line_t merge_bytes(line_t old, line_t data, mask_t m);
        for (int b = 0; b < mask_bits; b++) begin
            if (m[b]) begin
                old[8*b +: 8] = data[8*b +: 8];
            end
        end
        return old;
    endfunction

    // Root set means the left pair. A pair bit set means its lower way.
    function automatic way_t pick_victim(plru_t p);
        return p[0] ? {1'b0, ~p[1]} : {1'b1, ~p[2]};
    endfunction

    function automatic plru_t touch_way(plru_t p, way_t w);
        p[w[1] ? 2 : 1] = w[0];
        p[0] = w[1];
        return p;
    endfunction

    task automatic draw_bits(input int n, output line_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            v[i] = lfsr[0];
        end
    endtask

    task automatic check(input string name, input line_t got, input line_t exp);
        assert (got === exp) else begin
            errors = errors + 1;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic run_row(input row_t row);
        index_t idx;
        tag_t   tg;
        way_t   way;
        logic   found;
        logic   exp_wb;
        logic   got_fill;
        logic   got_wb;
        addr_t  victim_addr;
        line_t  wdata;
        line_t  rand_mask;
        mask_t  mask;
        int     cycles;

        idx    = row.addr[offset_bits +: index_bits];
        tg     = row.addr[offset_bits+index_bits +: tag_bits];
        mask   = row.mask;
        wdata  = '0;
        found  = 1'b0;
        exp_wb = 1'b0;
        if (row.is_write) begin
            if (mask == '0) begin
                draw_bits(mask_bits, rand_mask);
                mask = rand_mask[mask_bits-1:0];
            end
            draw_bits(line_bits, wdata);
            wdata = wdata ^ {8{row.seed}};
        end
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                way   = way_t'(w);
                found = 1'b1;
            end
        end
        if (!found) begin
            way         = pick_victim(ref_plru[idx]);
            exp_wb      = ref_valid[idx][way] && ref_dirty[idx][way];
            victim_addr = {ref_tag[idx][way], idx, offset_bits'(0)};
        end

        @(posedge clk);
        mem_read        <= !row.is_write;
        mem_write       <= row.is_write;
        mem_address     <= row.addr;
        mem_byte_enable <= row.is_write ? mask : '0;
        mem_wdata       <= wdata;

        cycles   = 0;
        got_fill = 1'b0;
        got_wb   = 1'b0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
            if (pmem_read) begin
                got_fill = 1'b1;
            end
            if (pmem_write) begin
                got_wb = 1'b1;
            end
            if (pmem_resp && pmem_read) begin
                check("pmem_address", pmem_address, row.addr);
            end
            if (pmem_resp && pmem_write) begin
                check("pmem_address", pmem_address, victim_addr);
                check("pmem_wdata", pmem_wdata, shadow_line(victim_addr));
            end
        end while (!mem_resp);

        if (!row.is_write) begin
            check("mem_rdata", mem_rdata, shadow_line(row.addr));
        end
        if (row.exp_hit) begin
            check("mem_resp cycle", cycles, 2);
        end
        check("pmem_read", got_fill, !row.exp_hit);
        check("pmem_write", got_wb, exp_wb);

        if (!found) begin
            ref_tag[idx][way]   = tg;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
        end
        if (exp_wb) begin
            wb_total = wb_total + 1;
        end
        ref_plru[idx] = touch_way(ref_plru[idx], way);
        if (row.is_write) begin
            ref_dirty[idx][way] = 1'b1;
            shadow[row.addr]    = merge_bytes(shadow_line(row.addr), wdata, mask);
        end

        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        // A second pulse would show up in the idle cycle after the request.
        @(negedge clk);
        check("mem_resp", mem_resp, 1'b0);
    endtask

    initial begin
        rst             = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        lfsr            = 16'd72;
        for (int s = 0; s < num_sets; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end
        check("wb_count", wb_count, wb_total);

        $display("Failed checks: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// ==== cache.f ====
source/cache_pkg.sv
source/cache_data_array.sv
source/cache_tag_array.sv
source/cache_status_array.sv
source/cache_datapath.sv
source/cache_control.sv
source/cache.sv
verification/pmem_model.sv
verification/cache_tb.sv
